// ==== sources.f ====
rv_mem_pkg.sv
store_align.sv
load_extend.sv
data_ram.sv
wb_select.sv
mem_stage.sv
mem_subsystem.sv
tb_mem_subsystem.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the memory-stage testbench with Verilator and runs it.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sources.f --top-module tb_mem_subsystem
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vtb_mem_subsystem > sim.log 2>&1
sim_status=$?
cat sim.log

if grep -q "Some tests failed" sim.log; then
  exit 1
fi
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi
exit 0

// ==== tb_mem_subsystem.sv ====
`timescale 1ns/1ps

module tb_mem_subsystem;
  import rv_mem_pkg::*;

  typedef struct packed {
    wb_out_t     out;
    logic        chk_lat;
    int unsigned acc_cycle;
  } exp_entry_t;

  logic clk;
  logic rst;
  logic ex_valid;
  ex_to_mem_t ex_bus;
  logic wb_ready = 1'b1;
  logic mem_allowin;
  logic wb_valid;
  wb_out_t wb_out;
  fwd_t fwd;

  exp_entry_t exp_q[$];
  logic [7:0] shadow [2048]; // Byte image of the RAM, indexed by address bits 10 to 0.
  ex_to_mem_t stage_pkt;
  logic started;
  logic bp_on;
  logic [63:0] next_pc;
  int unsigned cycle_count = 0;
  int unsigned out_count = 0;
  logic stall_prev = 1'b0;
  logic head_seen = 1'b0;
  wb_out_t held_out = '0;

  mem_subsystem mem_subsystem_inst (
    .clk         (clk),
    .rst         (rst),
    .ex_valid    (ex_valid),
    .ex_bus      (ex_bus),
    .wb_ready    (wb_ready),
    .mem_allowin (mem_allowin),
    .wb_valid    (wb_valid),
    .wb_out      (wb_out),
    .fwd         (fwd)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic fail_run(input string what);
    $display("%s", what);
    $display("Some tests failed");
    $fatal(1, "Simulation stopped at the first error.");
  endtask

  task automatic report_mismatch(input string field, input logic [63:0] got,
                                 input logic [63:0] expected);
    fail_run($sformatf("Mismatch at %0t ns: %s is %h, expected %h", $time, field, got,
                       expected));
  endtask

  task automatic compare_out(input string tag, input wb_out_t got, input wb_out_t expected);
    assert (got.pc == expected.pc)
      else report_mismatch({tag, ".pc"}, got.pc, expected.pc);
    assert (got.rd == expected.rd)
      else report_mismatch({tag, ".rd"}, 64'(got.rd), 64'(expected.rd));
    assert (got.rd_wen == expected.rd_wen)
      else report_mismatch({tag, ".rd_wen"}, 64'(got.rd_wen), 64'(expected.rd_wen));
    assert (got.data == expected.data)
      else report_mismatch({tag, ".data"}, got.data, expected.data);
  endtask

  function automatic logic [63:0] fill_pattern(input logic [10:0] a);
    return {a, ~a, a, ~a, a, a[8:0]};
  endfunction

  function automatic logic [10:0] dw_addr(input int unsigned k);
    return 11'(((k * 37 + 5) % 256) * 8); // Eight distinct doublewords spread over the RAM.
  endfunction

  function automatic int store_bytes(input store_op_t op);
    case (op)
      store_sb: return 1;
      store_sh: return 2;
      store_sw: return 4;
      default:  return 8;
    endcase
  endfunction

  function automatic int load_bytes(input load_op_t op);
    case (op)
      load_lb, load_lbu: return 1;
      load_lh, load_lhu: return 2;
      load_lw, load_lwu: return 4;
      default:           return 8;
    endcase
  endfunction

  function automatic logic [63:0] model_load(input load_op_t op, input logic [10:0] a);
    logic [63:0] raw;
    logic sign;
    int n;
    raw = '0;
    n = load_bytes(op);
    for (int i = 0; i < n; i++) begin
      raw[i*8 +: 8] = shadow[a + 11'(i)];
    end
    sign = raw[n*8-1] && (op inside {load_lb, load_lh, load_lw});
    for (int i = n; i < 8; i++) begin
      raw[i*8 +: 8] = {8{sign}};
    end
    return raw;
  endfunction

  task automatic push_expected(input ex_to_mem_t p, input logic chk_lat,
                               input int unsigned acc);
    exp_entry_t e;
    logic [10:0] a;
    a = p.alu_result[10:0];
    e.out.pc = p.pc;
    e.out.rd = p.rd;
    e.out.rd_wen = p.rd_wen;
    e.chk_lat = chk_lat;
    e.acc_cycle = acc;
    for (int i = 0; i < store_bytes(p.store_op) && p.store_op != store_none; i++) begin
      shadow[a + 11'(i)] = p.store_data[i*8 +: 8];
    end
    case (p.wb_sel)
      wb_load: e.out.data = model_load(p.load_op, a);
      wb_csr:  e.out.data = p.csr_data;
      default: e.out.data = p.alu_result;
    endcase
    exp_q.push_back(e);
  endtask

  function automatic ex_to_mem_t base_packet(input wb_sel_t sel);
    ex_to_mem_t p;
    p = '0;
    p.inst = $urandom;
    p.rd = 5'(1 + $urandom % 31);
    p.rd_wen = 1'b1;
    p.wb_sel = sel;
    p.alu_result = {$urandom, $urandom};
    p.csr_data = {$urandom, $urandom};
    p.store_data = {$urandom, $urandom};
    return p;
  endfunction

  function automatic ex_to_mem_t load_packet(input load_op_t op, input logic [10:0] a);
    ex_to_mem_t p;
    p = base_packet(wb_load);
    p.load_op = op;
    p.alu_result[10:0] = a; // Upper address bits stay random and are ignored by the RAM.
    return p;
  endfunction

  function automatic ex_to_mem_t store_packet(input store_op_t op, input logic [10:0] a,
                                              input logic [63:0] d);
    ex_to_mem_t p;
    p = base_packet(wb_alu);
    p.store_op = op;
    p.store_data = d;
    p.rd_wen = 1'b0;
    p.alu_result[10:0] = a;
    return p;
  endfunction

  function automatic logic [10:0] rand_addr(input int nbytes);
    logic [10:0] a;
    a = dw_addr($urandom % 8);
    a[2:0] = 3'((($urandom % 8) / nbytes) * nbytes);
    return a;
  endfunction

  function automatic ex_to_mem_t random_packet();
    ex_to_mem_t p;
    store_op_t sop;
    load_op_t lop;
    case ($urandom % 4)
      0: p = base_packet(wb_alu);
      1: p = base_packet(wb_csr);
      2: begin
        sop = store_op_t'(3'(1 + $urandom % 4));
        p = store_packet(sop, rand_addr(store_bytes(sop)), {$urandom, $urandom});
      end
      default: begin
        lop = load_op_t'(3'(1 + $urandom % 7));
        p = load_packet(lop, rand_addr(load_bytes(lop)));
      end
    endcase
    return p;
  endfunction

  task automatic idle(input int n);
    repeat (n) begin
      @(posedge clk);
      #10;
    end
  endtask

  // Holds the packet on ex_bus until the stage takes it.
  task automatic send(input ex_to_mem_t pkt, input logic chk_lat);
    ex_to_mem_t p;
    logic done;
    int unsigned acc;
    p = pkt;
    p.pc = next_pc;
    next_pc = next_pc + 64'd4;
    done = 1'b0;
    acc = 0;
    ex_valid = 1'b1;
    ex_bus = p;
    while (!done) begin
      @(negedge clk);
      done = mem_allowin;
      acc = cycle_count;
      @(posedge clk);
      if (done) begin
        push_expected(p, chk_lat, acc);
        stage_pkt = p;
        started = 1'b1;
      end
      #10;
    end
    ex_valid = 1'b0;
  endtask

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= 4000) begin
      fail_run("Timeout: the run did not finish within 4000 clock cycles.");
    end
  end

  always @(posedge clk) begin
    #10;
    wb_ready = bp_on ? ($urandom % 3 != 0) : 1'b1;
  end

  // Outputs are sampled at the falling edge, well away from the driven edges.
  always @(negedge clk) begin
    if (!rst) begin
      if (!started) begin
        assert (!wb_valid && !fwd.rd_wen)
          else fail_run("Writeback or forwarding was active before any packet was sent.");
      end
      if (stall_prev) begin
        assert (wb_valid) else fail_run("wb_valid dropped while wb_ready was low.");
        compare_out("held wb_out", wb_out, held_out);
      end
      if (!mem_allowin && !wb_valid) begin
        assert (fwd.rd == stage_pkt.rd)
          else report_mismatch("fwd.rd", 64'(fwd.rd), 64'(stage_pkt.rd));
        assert (fwd.rd_wen == stage_pkt.rd_wen)
          else report_mismatch("fwd.rd_wen", 64'(fwd.rd_wen), 64'(stage_pkt.rd_wen));
        assert (fwd.value == stage_pkt.alu_result)
          else report_mismatch("fwd.value", fwd.value, stage_pkt.alu_result);
      end
      if (wb_valid) begin
        if (out_count >= exp_q.size()) begin
          fail_run("wb_valid is high but no packet is outstanding.");
        end else begin
          if (!head_seen && exp_q[out_count].chk_lat) begin
            assert (cycle_count - exp_q[out_count].acc_cycle <= 2)
              else fail_run($sformatf("Packet at pc %h took too long to reach writeback.",
                                      exp_q[out_count].out.pc));
          end
          head_seen = 1'b1;
          if (wb_ready) begin
            compare_out("wb_out", wb_out, exp_q[out_count].out);
            out_count = out_count + 1;
            head_seen = 1'b0;
          end
        end
      end
      stall_prev = wb_valid && !wb_ready;
      held_out = wb_out;
    end
  end

  initial begin
    load_op_t lop;
    logic [10:0] a;
    ex_to_mem_t p;
    void'($urandom(32'h3b13_d6b1));
    rst = 1'b1;
    ex_valid = 1'b0;
    ex_bus = '0;
    bp_on = 1'b0;
    started = 1'b0;
    stage_pkt = '0;
    next_pc = 64'h0000_0000_8000_0000;
    repeat (16) @(posedge clk);
    #10;
    rst = 1'b0;
    idle(4);

    send(base_packet(wb_alu), 1'b0);
    send(base_packet(wb_csr), 1'b0);

    for (int k = 0; k < 8; k++) begin
      send(store_packet(store_sd, dw_addr(k), fill_pattern(dw_addr(k))), 1'b0);
    end
    send(store_packet(store_sb, dw_addr(0), 64'hffff_ffff_ffff_ff80), 1'b0);
    send(store_packet(store_sh, dw_addr(1) + 11'd2, 64'h1234_5678_9abc_8001), 1'b0);
    send(store_packet(store_sw, dw_addr(2) + 11'd4, 64'hdead_beef_f00d_cafe), 1'b0);
    send(store_packet(store_sb, dw_addr(3) + 11'd1, 64'h0000_0000_0000_007f), 1'b0);
    send(store_packet(store_sh, dw_addr(3) + 11'd6, 64'h0000_0000_0000_c3a5), 1'b0);
    for (int k = 0; k < 8; k++) begin
      for (int j = 1; j < 8; j++) begin
        lop = load_op_t'(3'(j));
        a = dw_addr(k);
        a[2:0] = 3'(((k * 3) % 8) / load_bytes(lop) * load_bytes(lop));
        send(load_packet(lop, a), 1'b0);
      end
    end

    bp_on = 1'b1;
    for (int n = 0; n < 80; n++) begin
      send(random_packet(), 1'b0);
      idle($urandom % 3);
    end
    bp_on = 1'b0;
    idle(4);

    for (int n = 0; n < 40; n++) begin
      p = random_packet();
      send(p, (p.load_op == load_none) && (p.store_op == store_none));
    end

    // Two packets in flight drain well within this many cycles.
    for (int n = 0; n < 64 && out_count != exp_q.size(); n++) begin
      idle(1);
    end
    idle(3);
    if (out_count != exp_q.size()) begin
      fail_run("Expected writebacks are still outstanding at the end of the run.");
    end else begin
      $display("All tests passed");
      $finish;
    end
  end

endmodule

// ==== mem_subsystem.sv ====
`timescale 1ns/1ps

module mem_subsystem (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   ex_valid,
  input  rv_mem_pkg::ex_to_mem_t ex_bus,
  input  logic                   wb_ready,
  output logic                   mem_allowin,
  output logic                   wb_valid,
  output rv_mem_pkg::wb_out_t    wb_out,
  output rv_mem_pkg::fwd_t       fwd
);
  import rv_mem_pkg::*;

  logic mem_to_wb_valid;
  mem_to_wb_t mem_to_wb;
  logic wb_allowin;
  logic req_valid;
  mem_req_t req;
  logic req_ready;
  logic [xlen-1:0] rdata;

  mem_stage mem_stage_inst (
    .clk             (clk),
    .rst             (rst),
    .ex_valid        (ex_valid),
    .ex_bus          (ex_bus),
    .mem_allowin     (mem_allowin),
    .mem_to_wb_valid (mem_to_wb_valid),
    .mem_to_wb       (mem_to_wb),
    .wb_allowin      (wb_allowin),
    .req_valid       (req_valid),
    .req             (req),
    .req_ready       (req_ready),
    .rdata           (rdata),
    .fwd             (fwd)
  );

  data_ram data_ram_inst (
    .clk       (clk),
    .rst       (rst),
    .req_valid (req_valid),
    .req       (req),
    .req_ready (req_ready),
    .rdata     (rdata)
  );

  wb_select wb_select_inst (
    .clk             (clk),
    .rst             (rst),
    .mem_to_wb_valid (mem_to_wb_valid),
    .mem_to_wb       (mem_to_wb),
    .wb_ready        (wb_ready),
    .wb_allowin      (wb_allowin),
    .wb_valid        (wb_valid),
    .wb_out          (wb_out)
  );

endmodule

// ==== mem_stage.sv ====
`timescale 1ns/1ps

module mem_stage (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        ex_valid,
  input  rv_mem_pkg::ex_to_mem_t      ex_bus,
  output logic                        mem_allowin,
  output logic                        mem_to_wb_valid,
  output rv_mem_pkg::mem_to_wb_t      mem_to_wb,
  input  logic                        wb_allowin,
  output logic                        req_valid,
  output rv_mem_pkg::mem_req_t        req,
  input  logic                        req_ready,
  input  logic [rv_mem_pkg::xlen-1:0] rdata,
  output rv_mem_pkg::fwd_t            fwd
);
  import rv_mem_pkg::*;

  typedef enum logic [1:0] {
    state_idle,
    state_request,
    state_done
  } state_t;

  state_t state;
  state_t state_next;
  logic mem_valid;
  ex_to_mem_t mem_r;
  logic accept;
  logic handshake;
  logic ex_has_mem;
  logic mem_has_mem;
  logic mem_ready_go;
  logic [xlen-1:0] load_data;

  assign ex_has_mem  = (ex_bus.load_op != load_none) || (ex_bus.store_op != store_none);
  assign mem_has_mem = (mem_r.load_op != load_none) || (mem_r.store_op != store_none);

  assign mem_ready_go    = (state == state_done) || !mem_has_mem;
  assign mem_allowin     = !mem_valid || (mem_ready_go && wb_allowin);
  assign mem_to_wb_valid = mem_valid && mem_ready_go;
  assign accept          = ex_valid && mem_allowin;
  assign handshake       = req_valid && req_ready;
  assign req_valid       = state == state_request;

  always_ff @(posedge clk) begin
    if (rst) begin
      mem_valid <= 1'b0;
    end else if (mem_allowin) begin
      mem_valid <= ex_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      mem_r <= ex_bus;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= state_idle;
    end else begin
      state <= state_next;
    end
  end

  // The request starts the cycle after the packet is accepted.
  always_comb begin
    state_next = state;
    case (state)
      state_idle: begin
        if (accept && ex_has_mem) begin
          state_next = state_request;
        end
      end
      state_request: begin
        if (handshake) begin
          state_next = state_done;
        end
      end
      state_done: begin
        if (accept && ex_has_mem) begin
          state_next = state_request;
        end else if (mem_allowin) begin
          state_next = state_idle;
        end
      end
      default: begin
        state_next = state_idle;
      end
    endcase
  end

  store_align store_align_inst (
    .load_op    (mem_r.load_op),
    .store_op   (mem_r.store_op),
    .store_data (mem_r.store_data),
    .alu_result (mem_r.alu_result),
    .req        (req)
  );

  load_extend load_extend_inst (
    .clk       (clk),
    .load_op   (mem_r.load_op),
    .rdata     (rdata),
    .capture   (handshake),
    .load_data (load_data)
  );

  assign mem_to_wb.pc         = mem_r.pc;
  assign mem_to_wb.inst       = mem_r.inst;
  assign mem_to_wb.rd         = mem_r.rd;
  assign mem_to_wb.rd_wen     = mem_r.rd_wen;
  assign mem_to_wb.wb_sel     = mem_r.wb_sel;
  assign mem_to_wb.alu_result = mem_r.alu_result;
  assign mem_to_wb.load_data  = load_data;
  assign mem_to_wb.csr_data   = mem_r.csr_data;

  assign fwd.rd     = mem_valid ? mem_r.rd : 5'd0; // Empty stage forwards nothing.
  assign fwd.rd_wen = mem_valid && mem_r.rd_wen;
  assign fwd.value  = mem_valid ? mem_r.alu_result : '0;

endmodule

// ==== wb_select.sv ====
`timescale 1ns/1ps

module wb_select (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   mem_to_wb_valid,
  input  rv_mem_pkg::mem_to_wb_t mem_to_wb,
  input  logic                   wb_ready,
  output logic                   wb_allowin,
  output logic                   wb_valid,
  output rv_mem_pkg::wb_out_t    wb_out
);
  import rv_mem_pkg::*;

  logic [xlen-1:0] sel_data;

  always_comb begin
    case (mem_to_wb.wb_sel)
      wb_load: sel_data = mem_to_wb.load_data;
      wb_csr:  sel_data = mem_to_wb.csr_data;
      default: sel_data = mem_to_wb.alu_result;
    endcase
  end

  assign wb_allowin = !wb_valid || wb_ready; // Room when empty or the entry leaves now.

  always_ff @(posedge clk) begin
    if (rst) begin
      wb_valid <= 1'b0;
    end else if (wb_allowin) begin
      wb_valid <= mem_to_wb_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (mem_to_wb_valid && wb_allowin) begin
      wb_out.pc     <= mem_to_wb.pc;
      wb_out.rd     <= mem_to_wb.rd;
      wb_out.rd_wen <= mem_to_wb.rd_wen;
      wb_out.data   <= sel_data;
    end
  end

endmodule

// ==== data_ram.sv ====
`timescale 1ns/1ps

module data_ram (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        req_valid,
  input  rv_mem_pkg::mem_req_t        req,
  output logic                        req_ready,
  output logic [rv_mem_pkg::xlen-1:0] rdata
);
  import rv_mem_pkg::*;

  logic [xlen-1:0] mem [ram_depth];
  logic [7:0] lfsr;
  logic busy;
  logic [1:0] wait_cnt;
  logic [1:0] delay;
  logic [ram_addr_bits-4:0] idx;
  logic [2:0] offset;
  logic [7:0] size_mask;
  logic [7:0] byte_en;
  logic [xlen-1:0] wdata_shift;

  assign idx    = req.addr[ram_addr_bits-1:3];
  assign offset = req.addr[2:0];

  always_comb begin
    case (req.size)
      size_byte: size_mask = 8'b0000_0001;
      size_half: size_mask = 8'b0000_0011;
      size_word: size_mask = 8'b0000_1111;
      default:   size_mask = 8'b1111_1111;
    endcase
  end

  assign byte_en     = size_mask << offset;
  assign wdata_shift = req.wdata << {offset, 3'b000};
  assign rdata       = mem[idx] >> {offset, 3'b000};

  // A fresh request takes its delay straight from the LFSR.
  assign delay     = busy ? wait_cnt : lfsr[1:0];
  assign req_ready = req_valid && (delay == 2'd0);

  always_ff @(posedge clk) begin
    if (rst) begin
      lfsr     <= 8'ha5;
      busy     <= 1'b0;
      wait_cnt <= 2'd0;
    end else begin
      lfsr <= {lfsr[6:0], lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3]};
      if (req_valid && req_ready) begin
        busy <= 1'b0;
      end else if (req_valid && !busy) begin
        busy     <= 1'b1;
        wait_cnt <= lfsr[1:0] - 2'd1;
      end else if (busy) begin
        wait_cnt <= wait_cnt - 2'd1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (req_valid && req_ready && req.write) begin
      for (int i = 0; i < 8; i++) begin
        if (byte_en[i]) begin
          mem[idx][i*8 +: 8] <= wdata_shift[i*8 +: 8];
        end
      end
    end
  end

endmodule

// ==== load_extend.sv ====
`timescale 1ns/1ps

module load_extend (
  input  logic                        clk,
  input  rv_mem_pkg::load_op_t        load_op,
  input  logic [rv_mem_pkg::xlen-1:0] rdata,
  input  logic                        capture,
  output logic [rv_mem_pkg::xlen-1:0] load_data
);
  import rv_mem_pkg::*;

  logic [xlen-1:0] ext_data;

  always_comb begin
    case (load_op)
      load_lb:  ext_data = {{56{rdata[7]}}, rdata[7:0]};
      load_lh:  ext_data = {{48{rdata[15]}}, rdata[15:0]};
      load_lw:  ext_data = {{32{rdata[31]}}, rdata[31:0]};
      load_ld:  ext_data = rdata;
      load_lbu: ext_data = {56'b0, rdata[7:0]};
      load_lhu: ext_data = {48'b0, rdata[15:0]};
      load_lwu: ext_data = {32'b0, rdata[31:0]};
      default:  ext_data = '0;
    endcase
  end

  // rdata is only valid in the handshake cycle, so the result is kept here.
  always_ff @(posedge clk) begin
    if (capture) begin
      load_data <= ext_data;
    end
  end

endmodule

// ==== store_align.sv ====
`timescale 1ns/1ps

module store_align (
  input  rv_mem_pkg::load_op_t          load_op,
  input  rv_mem_pkg::store_op_t         store_op,
  input  logic [rv_mem_pkg::xlen-1:0]   store_data,
  input  logic [rv_mem_pkg::xlen-1:0]   alu_result,
  output rv_mem_pkg::mem_req_t          req
);
  import rv_mem_pkg::*;

  acc_size_t acc_size;
  logic [xlen-1:0] data_mask;

  always_comb begin
    acc_size = size_double;
    if (store_op != store_none) begin
      case (store_op)
        store_sb: acc_size = size_byte;
        store_sh: acc_size = size_half;
        store_sw: acc_size = size_word;
        default:  acc_size = size_double;
      endcase
    end else begin
      case (load_op)
        load_lb, load_lbu: acc_size = size_byte;
        load_lh, load_lhu: acc_size = size_half;
        load_lw, load_lwu: acc_size = size_word;
        default:           acc_size = size_double;
      endcase
    end
  end

  always_comb begin
    case (acc_size)
      size_byte: data_mask = 64'h0000_0000_0000_00ff;
      size_half: data_mask = 64'h0000_0000_0000_ffff;
      size_word: data_mask = 64'h0000_0000_ffff_ffff;
      default:   data_mask = '1;
    endcase
  end

  assign req.addr  = alu_result;
  assign req.wdata = store_data & data_mask; // Data sits in lane 0 before the RAM shifts it.
  assign req.size  = acc_size;
  assign req.write = store_op != store_none;

endmodule

// ==== rv_mem_pkg.sv ====
package rv_mem_pkg;

  localparam int unsigned xlen          = 64;
  localparam int unsigned ram_depth     = 256; // Doublewords.
  localparam int unsigned ram_addr_bits = 11;  // Byte address bits the RAM decodes.

  typedef enum logic [2:0] {
    load_none,
    load_lb,
    load_lh,
    load_lw,
    load_ld,
    load_lbu,
    load_lhu,
    load_lwu
  } load_op_t;

  typedef enum logic [2:0] {
    store_none,
    store_sb,
    store_sh,
    store_sw,
    store_sd
  } store_op_t;

  typedef enum logic [1:0] {
    size_byte,
    size_half,
    size_word,
    size_double
  } acc_size_t;

  typedef enum logic [1:0] {
    wb_alu,
    wb_load,
    wb_csr
  } wb_sel_t;

  typedef struct packed {
    logic [63:0]     pc;
    logic [31:0]     inst;
    load_op_t        load_op;
    store_op_t       store_op;
    logic [xlen-1:0] store_data;
    logic [xlen-1:0] alu_result; // Also the memory byte address.
    logic [xlen-1:0] csr_data;
    logic [4:0]      rd;
    logic            rd_wen;
    wb_sel_t         wb_sel;
  } ex_to_mem_t;

  typedef struct packed {
    logic [xlen-1:0] addr;
    logic [xlen-1:0] wdata;
    acc_size_t       size;
    logic            write;
  } mem_req_t;

  typedef struct packed {
    logic [63:0]     pc;
    logic [31:0]     inst;
    logic [4:0]      rd;
    logic            rd_wen;
    wb_sel_t         wb_sel;
    logic [xlen-1:0] alu_result;
    logic [xlen-1:0] load_data;
    logic [xlen-1:0] csr_data;
  } mem_to_wb_t;

  typedef struct packed {
    logic [63:0]     pc;
    logic [4:0]      rd;
    logic            rd_wen;
    logic [xlen-1:0] data;
  } wb_out_t;

  typedef struct packed {
    logic [4:0]      rd;
    logic            rd_wen;
    logic [xlen-1:0] value;
  } fwd_t;

endpackage
